/* compile.f */
+incdir+include
rtl/ion_pkg.sv
rtl/sample_if.sv
rtl/ion_apb_regs.sv
rtl/record_sequencer.sv
rtl/record_rom.sv
rtl/packet_framer.sv
rtl/ion_sensor_top.sv
verification/ion_sensor_tb.sv

/* include/ion_record_table.svh */
// the 60 recorded ion sensor samples, included inside the record ROM module body.
`ifndef ion_record_table_svh
`define ion_record_table_svh

// flag, ion level, aux level, timestamp, check word.
localparam ion_record_t record_table [num_records] = '{
	'{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110},
	'{1'b1, 8'd176, 8'd100, 16'd925, 16'd3791},
	'{1'b0, 8'd177, 8'd100, 16'd962, 16'd63275},
	'{1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574},
	'{1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019},
	'{1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527},
	'{1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177},
	'{1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222},
	'{1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756},
	'{1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961},
	'{1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993},
	'{1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675},
	'{1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473},
	'{1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224},
	'{1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195},
	'{1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996},
	'{1'b1, 8'd177, 8'd100, 16'd1556, 16'd145},
	'{1'b1, 8'd178, 8'd100, 16'd1598, 16'd21191},
	'{1'b0, 8'd177, 8'd100, 16'd1635, 16'd610},
	'{1'b1, 8'd177, 8'd100, 16'd1679, 16'd4089},
	// records 20 to 39.
	'{1'b0, 8'd178, 8'd100, 16'd1729, 16'd20685},
	'{1'b1, 8'd177, 8'd100, 16'd1766, 16'd10459},
	'{1'b1, 8'd178, 8'd100, 16'd1815, 16'd57766},
	'{1'b0, 8'd177, 8'd100, 16'd1857, 16'd48236},
	'{1'b1, 8'd177, 8'd100, 16'd1903, 16'd36453},
	'{1'b0, 8'd183, 8'd100, 16'd1945, 16'd22977},
	'{1'b0, 8'd177, 8'd100, 16'd1987, 16'd13045},
	'{1'b0, 8'd177, 8'd100, 16'd2033, 16'd40993},
	'{1'b1, 8'd177, 8'd100, 16'd2075, 16'd45310},
	'{1'b1, 8'd177, 8'd100, 16'd2108, 16'd62988},
	'{1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032},
	'{1'b1, 8'd178, 8'd100, 16'd2199, 16'd22312},
	'{1'b0, 8'd177, 8'd100, 16'd2248, 16'd48507},
	'{1'b0, 8'd178, 8'd101, 16'd2286, 16'd3615},
	'{1'b1, 8'd177, 8'd100, 16'd2335, 16'd31043},
	'{1'b0, 8'd177, 8'd100, 16'd2381, 16'd65151},
	'{1'b0, 8'd177, 8'd100, 16'd2423, 16'd45123},
	'{1'b0, 8'd177, 8'd100, 16'd2465, 16'd47297},
	'{1'b0, 8'd177, 8'd100, 16'd2498, 16'd1374},
	'{1'b0, 8'd180, 8'd100, 16'd2548, 16'd8510},
	// records 40 to 59.
	'{1'b1, 8'd178, 8'd100, 16'd2581, 16'd3766},
	'{1'b0, 8'd178, 8'd100, 16'd2631, 16'd15678},
	'{1'b0, 8'd178, 8'd100, 16'd2670, 16'd46144},
	'{1'b1, 8'd176, 8'd100, 16'd2712, 16'd43275},
	'{1'b1, 8'd185, 8'd100, 16'd2758, 16'd6402},
	'{1'b0, 8'd178, 8'd100, 16'd2800, 16'd28324},
	'{1'b0, 8'd177, 8'd100, 16'd2842, 16'd41123},
	'{1'b0, 8'd178, 8'd100, 16'd2888, 16'd25754},
	'{1'b1, 8'd177, 8'd100, 16'd2926, 16'd43754},
	'{1'b0, 8'd177, 8'd100, 16'd2973, 16'd37758},
	'{1'b0, 8'd177, 8'd100, 16'd3015, 16'd62364},
	'{1'b1, 8'd177, 8'd100, 16'd3057, 16'd48200},
	'{1'b1, 8'd178, 8'd100, 16'd3100, 16'd56276},
	'{1'b0, 8'd178, 8'd100, 16'd3146, 16'd59933},
	'{1'b0, 8'd177, 8'd101, 16'd3184, 16'd30250},
	'{1'b1, 8'd178, 8'd100, 16'd3233, 16'd49966},
	'{1'b1, 8'd177, 8'd100, 16'd3267, 16'd662},
	'{1'b1, 8'd178, 8'd100, 16'd3308, 16'd47031},
	'{1'b1, 8'd178, 8'd100, 16'd3349, 16'd2734},
	'{1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121}
};

`endif

/* rtl/ion_apb_regs.sv */
// APB slave with enable, pacing period and packets-sent count; sits beside the playback stages.
`timescale 1ns/10ps
`default_nettype none

module ion_apb_regs import ion_pkg::*; #(
	parameter period_t default_period = 16'haaaa
) (
	input wire clock,
	input wire resetn,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_addr_t paddr,
	input wire [31:0] pwdata,
	input wire packet_valid,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic enable,
	output period_t period
);

	logic access;
	logic addr_hit;
	logic wr_en;
	count_t count;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign access = psel & penable;
	assign addr_hit = (paddr == reg_ctrl) || (paddr == reg_period) || (paddr == reg_count);
	assign wr_en = access & pwrite;

	// no wait states.
	assign pready = 1'b1;
	assign pslverr = access & ~addr_hit;

	always_comb
	begin
		case (paddr)
			reg_ctrl: prdata = {31'd0, enable};
			reg_period: prdata = {16'd0, period};
			reg_count: prdata = {16'd0, count};
			default: prdata = 32'd0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			enable <= 1'b0;
			period <= default_period;
		end
		else if (wr_en)
		begin
			// count writes fall through here.
			if (paddr == reg_ctrl)
				enable <= pwdata[0];
			else if (paddr == reg_period)
				period <= pwdata[15:0];
		end
	end

	// wraps at 16 bits.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (packet_valid)
			count <= count + 16'd1;
	end

endmodule

`default_nettype wire

/* rtl/ion_pkg.sv */
// shared widths, packet constants, record and packet types and APB map; imported by all units.
`default_nettype none

package ion_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// table size and counter widths.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int num_records = 60;

	typedef logic [5:0] index_t;
	typedef logic [15:0] period_t;
	typedef logic [15:0] count_t;

	// constant fields of every sensor packet.
	localparam logic [6:0] header_code = 7'd77;
	localparam logic [7:0] sync_byte = 8'd255;
	localparam logic [7:0] marker_hi = 8'd239;
	localparam logic [7:0] marker_lo = 8'd17;
	localparam logic [5:0] channel_id = 6'd1;
	localparam logic [23:0] device_id = 24'd4272433;

	// varying part of one recorded sample.
	typedef struct packed {
		logic flag;
		logic [7:0] ion_level;
		logic [7:0] aux_level;
		logic [15:0] timestamp;
		logic [15:0] check_word;
	} ion_record_t;

	// full packet, header_code sits in the low bits.
	typedef struct packed {
		logic [23:0] device_id;
		logic [5:0] channel;
		logic [15:0] check_word;
		logic [7:0] marker_lo;
		logic [7:0] marker_hi;
		logic [15:0] timestamp;
		logic [7:0] aux_level;
		logic [7:0] ion_level;
		logic [7:0] sync;
		logic flag;
		logic [6:0] header_code;
	} ion_packet_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB register map, byte addresses.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [3:0] apb_addr_t;

	localparam apb_addr_t reg_ctrl = 4'h0;
	localparam apb_addr_t reg_period = 4'h4;
	localparam apb_addr_t reg_count = 4'h8;

endpackage

`default_nettype wire

/* rtl/ion_sensor_top.sv */
// top level of the ion sensor playback source; APB configuration plus the three-stage pipeline.
`timescale 1ns/10ps
`default_nettype none

module ion_sensor_top import ion_pkg::*; #(
	parameter period_t default_period = 16'haaaa
) (
	input wire clock,
	input wire resetn,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire apb_addr_t paddr,
	input wire [31:0] pwdata,
	output wire [31:0] prdata,
	output wire pready,
	output wire pslverr,
	output wire packet_valid,
	output wire ion_packet_t packet_data
);

	logic enable;
	period_t period;
	logic tick;
	index_t index;

	sample_if rec ();

	ion_apb_regs #(
		.default_period(default_period)
	) u_regs (
		.clock(clock),
		.resetn(resetn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.packet_valid(packet_valid),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.enable(enable),
		.period(period)
	);

	// tick, then record one cycle later, then packet.
	record_sequencer u_sequencer (
		.clock(clock),
		.resetn(resetn),
		.enable(enable),
		.period(period),
		.tick(tick),
		.index(index)
	);

	record_rom u_rom (
		.clock(clock),
		.resetn(resetn),
		.tick(tick),
		.index(index),
		.rec(rec.source)
	);

	packet_framer u_framer (
		.clock(clock),
		.resetn(resetn),
		.rec(rec.sink),
		.packet_valid(packet_valid),
		.packet_data(packet_data)
	);

endmodule

`default_nettype wire

/* rtl/packet_framer.sv */
// third playback stage; frames a sample record into the 110-bit packet with a one-cycle strobe.
`timescale 1ns/10ps
`default_nettype none

module packet_framer import ion_pkg::*; (
	input wire clock,
	input wire resetn,
	sample_if.sink rec,
	output logic packet_valid,
	output ion_packet_t packet_data
);

	ion_packet_t framed;

	// record fields between the fixed ones.
	always_comb
	begin
		framed.header_code = header_code;
		framed.flag = rec.flag;
		framed.sync = sync_byte;
		framed.ion_level = rec.ion_level;
		framed.aux_level = rec.aux_level;
		framed.timestamp = rec.timestamp;
		framed.marker_hi = marker_hi;
		framed.marker_lo = marker_lo;
		framed.check_word = rec.check_word;
		framed.channel = channel_id;
		framed.device_id = device_id;
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			packet_valid <= 1'b0;
			packet_data <= '0;
		end
		else
		begin
			packet_valid <= rec.valid;
			// data holds between strobes.
			if (rec.valid)
				packet_data <= framed;
		end
	end

endmodule

`default_nettype wire

/* rtl/record_rom.sv */
// second playback stage; registered lookup of the sample table, driven out on sample_if.
`timescale 1ns/10ps
`default_nettype none

module record_rom import ion_pkg::*; (
	input wire clock,
	input wire resetn,
	input wire tick,
	input wire index_t index,
	sample_if.source rec
);

`include "ion_record_table.svh"

	ion_record_t entry;

	assign entry = record_table[index];

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			rec.valid <= 1'b0;
		else
			rec.valid <= tick;
	end

	// payload, loaded only on tick.
	always_ff @(posedge clock)
	begin
		if (tick)
		begin
			rec.index <= index;
			rec.flag <= entry.flag;
			rec.ion_level <= entry.ion_level;
			rec.aux_level <= entry.aux_level;
			rec.timestamp <= entry.timestamp;
			rec.check_word <= entry.check_word;
		end
	end

endmodule

`default_nettype wire

/* rtl/record_sequencer.sv */
// first playback stage; pacing timer that ticks once per period and steps the record index.
`timescale 1ns/10ps
`default_nettype none

module record_sequencer import ion_pkg::*; (
	input wire clock,
	input wire resetn,
	input wire enable,
	input wire period_t period,
	output logic tick,
	output index_t index
);

	localparam index_t last_index = index_t'(num_records - 1);

	period_t timer;

	// >= so a shortened period cannot strand the timer above its limit.
	assign tick = enable && (timer >= period - 16'd1);

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			timer <= '0;
			index <= '0;
		end
		else if (!enable)
		begin
			timer <= '0;
			index <= '0;
		end
		else if (tick)
		begin
			timer <= '0;
			index <= (index == last_index) ? '0 : index + 6'd1;
		end
		else
			timer <= timer + 16'd1;
	end

endmodule

`default_nettype wire

/* rtl/sample_if.sv */
// carries one looked-up sample record from the record ROM stage to the packet framer stage.
`timescale 1ns/10ps
`default_nettype none

interface sample_if import ion_pkg::*; ();

	// valid pulses once per record, fields hold until the next one.
	logic valid;
	index_t index;
	logic flag;
	logic [7:0] ion_level;
	logic [7:0] aux_level;
	logic [15:0] timestamp;
	logic [15:0] check_word;

	modport source (
		output valid, index, flag, ion_level, aux_level, timestamp, check_word
	);

	modport sink (
		input valid, index, flag, ion_level, aux_level, timestamp, check_word
	);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module ion_sensor_tb -o ion_sensor_sim
./obj_dir/ion_sensor_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* verification/ion_sensor_tb.sv */
// self-checking testbench for the ion sensor playback source; drives APB and checks packets.
`timescale 1ns/10ps
`default_nettype none

module ion_sensor_tb import ion_pkg::*; ();

	localparam int num_rows = 6;

	logic clock;
	logic resetn;
	logic psel;
	logic penable;
	logic pwrite;
	apb_addr_t paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic packet_valid;
	ion_packet_t packet_data;

	int cycle;
	int pulse_total;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	// stimulus rows: period, packets to observe, expected first index.
	int row_period [num_rows];
	int row_packets [num_rows];
	int row_first [num_rows];

	ion_sensor_top #(
		.default_period(16'haaaa)
	) uut (
		.clock(clock),
		.resetn(resetn),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.packet_valid(packet_valid),
		.packet_data(packet_data)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	// cycle count and pulse count, sampled after the edge settles.
	initial
	begin
		cycle = 0;
		pulse_total = 0;
		forever
		begin
			@(posedge clock);
			cycle = cycle + 1;
			#2;
			if (packet_valid === 1'b1)
				pulse_total = pulse_total + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// expected values.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic known_record(input int index);
		return (index <= 3) || (index == 59);
	endfunction

	function automatic ion_record_t expected_record(input int index);
		ion_record_t r;
		case (index)
			0: r = '{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
			1: r = '{1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
			2: r = '{1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
			3: r = '{1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			59: r = '{1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121};
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic ion_packet_t expected_packet(input ion_record_t r);
		ion_packet_t p;
		p.header_code = header_code;
		p.flag = r.flag;
		p.sync = sync_byte;
		p.ion_level = r.ion_level;
		p.aux_level = r.aux_level;
		p.timestamp = r.timestamp;
		p.marker_hi = marker_hi;
		p.marker_lo = marker_lo;
		p.check_word = r.check_word;
		p.channel = channel_id;
		p.device_id = device_id;
		return p;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		errors = errors + 1;
		test_errors = test_errors + 1;
	endtask

	task automatic finish_test(input string name);
		tests_run = tests_run + 1;
		if (test_errors == 0)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
		end
		test_errors = 0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB driver, setup then access.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apb_transfer(input logic write, input apb_addr_t addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		@(posedge clock);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clock);
		#1;
		penable = 1'b1;
		#1;
		rdata = prdata;
		err = pslverr;
		if (pready !== 1'b1)
			report_mismatch($sformatf("pready low in access to 0x%h", addr));
		@(posedge clock);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, input logic want_err);
		logic [31:0] rdata;
		logic err;
		apb_transfer(1'b1, addr, data, rdata, err);
		if (err !== want_err)
			report_mismatch($sformatf("write 0x%h pslverr %b, expected %b", addr, err, want_err));
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic [31:0] want, input logic want_err);
		logic [31:0] rdata;
		logic err;
		apb_transfer(1'b0, addr, 32'd0, rdata, err);
		if (err !== want_err)
			report_mismatch($sformatf("read 0x%h pslverr %b, expected %b", addr, err, want_err));
		if (!want_err && rdata !== want)
			report_mismatch($sformatf("read 0x%h gave 0x%h, expected 0x%h", addr, rdata, want));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// packet monitor.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic wait_pulse(input int limit, output int when);
		int waited;
		waited = 0;
		when = -1;
		while (when < 0 && !timed_out)
		begin
			@(posedge clock);
			#2;
			if (packet_valid === 1'b1)
				when = cycle;
			else if (waited >= limit)
			begin
				$display("timeout: no packet_valid pulse within %0d cycles at %0t", limit, $time);
				timed_out = 1'b1;
				errors = errors + 1;
				test_errors = test_errors + 1;
			end
			waited = waited + 1;
		end
	endtask

	task automatic check_idle(input int cycles);
		for (int n = 0; n < cycles; n++)
		begin
			@(posedge clock);
			#2;
			if (packet_valid !== 1'b0)
				report_mismatch("packet_valid high while disabled");
		end
	endtask

	task automatic run_row(input int row);
		int period;
		int index;
		int when;
		int last_when;
		ion_packet_t want;
		period = row_period[row];
		index = row_first[row];
		last_when = -1;
		apb_write(reg_period, 32'(period), 1'b0);
		apb_write(reg_ctrl, 32'd1, 1'b0);
		for (int n = 0; n < row_packets[row] && !timed_out; n++)
		begin
			wait_pulse(2 * period + 20, when);
			if (!timed_out)
			begin
				if (last_when >= 0 && when - last_when != period)
					report_mismatch($sformatf("gap %0d cycles, expected %0d", when - last_when,
						period));
				if (known_record(index))
				begin
					want = expected_packet(expected_record(index));
					if (packet_data !== want)
						report_mismatch($sformatf("packet %0d gave %h, expected %h", n + 1,
							packet_data, want));
				end
				@(posedge clock);
				#2;
				if (packet_valid !== 1'b0)
					report_mismatch("packet_valid wider than one cycle");
				last_when = when;
				index = (index + 1) % num_records;
			end
		end
		// stop, let the pipeline drain, then nothing more may come out.
		apb_write(reg_ctrl, 32'd0, 1'b0);
		repeat (3) @(posedge clock);
		check_idle(2 * period + 4);
		apb_read(reg_count, {16'd0, pulse_total[15:0]}, 1'b0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		resetn = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		void'($urandom(32'he996e46a));

		// contents, three random paces, wrap, re-enable.
		row_period[0] = 4;
		row_packets[0] = 4;
		row_first[0] = 0;
		for (int r = 1; r <= 3; r++)
		begin
			row_period[r] = 3 + int'($urandom % 7);
			row_packets[r] = 6;
			row_first[r] = 0;
		end
		row_period[4] = 3;
		row_packets[4] = 61;
		row_first[4] = 0;
		row_period[5] = 5;
		row_packets[5] = 3;
		row_first[5] = 0;

		repeat (5) @(posedge clock);
		#1;
		resetn = 1'b1;

		check_idle(20);
		apb_read(reg_ctrl, 32'd0, 1'b0);
		apb_read(reg_period, 32'h0000aaaa, 1'b0);
		apb_read(reg_count, 32'd0, 1'b0);
		finish_test("reset values");

		// long period so no packet leaves while enable is briefly set.
		apb_write(reg_period, 32'h00001234, 1'b0);
		apb_read(reg_period, 32'h00001234, 1'b0);
		apb_write(reg_ctrl, 32'd1, 1'b0);
		apb_read(reg_ctrl, 32'd1, 1'b0);
		apb_write(reg_ctrl, 32'd0, 1'b0);
		apb_read(reg_ctrl, 32'd0, 1'b0);
		apb_read(4'hc, 32'd0, 1'b1);
		apb_write(4'hc, 32'h5a5a5a5a, 1'b1);
		apb_write(reg_count, 32'h00000055, 1'b0);
		apb_read(reg_count, 32'd0, 1'b0);
		finish_test("apb access");

		for (int r = 0; r < num_rows && !timed_out; r++)
		begin
			run_row(r);
			finish_test($sformatf("row %0d period %0d packets %0d", r, row_period[r],
				row_packets[r]));
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
